// ==== cpu16.f ====
+incdir+verilog
+incdir+tb
verilog/cpu16Pkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/fetchUnit.sv
verilog/dataMem.sv
verilog/cpuCore.sv
tb/cpuCoreTb.sv

// ==== tb/refModel.svh ====
// ISA reference model
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Model architectural state
logic [`CPU16_WIDTH-1:0] mRegs [`CPU16_REGS];
logic [`CPU16_WIDTH-1:0] mMem [`CPU16_DMEM_WORDS];
logic [`CPU16_WIDTH-1:0] mPc;

// Registers and PC clear, data memory keeps its words
function automatic void resetModel();
    int r;
    for (r = 0; r < `CPU16_REGS; r++) begin
        mRegs[r] = '0;
    end
    mPc = '0;
endfunction

// Executes one instruction, reports the register write and the next PC
function automatic void refStep(
    input  logic [`CPU16_WIDTH-1:0] ins,
    output logic                    expEn,
    output logic [2:0]              expAddr,
    output logic [`CPU16_WIDTH-1:0] expData,
    output logic [`CPU16_WIDTH-1:0] nextPc,
    output logic                    isHalt
);
    logic [4:0]              opc;
    logic [2:0]              rs;
    logic [2:0]              rt;
    logic [2:0]              rd;
    logic [`CPU16_WIDTH-1:0] s5;
    logic [`CPU16_WIDTH-1:0] z5;
    logic [`CPU16_WIDTH-1:0] s8;
    logic [`CPU16_WIDTH-1:0] s11;
    logic [`CPU16_WIDTH-1:0] a;
    logic [`CPU16_WIDTH-1:0] b;
    logic [`CPU16_WIDTH-1:0] seqPc;
    int                      memIdx;

    opc = ins[15:11];
    rs  = ins[10:8];
    rt  = ins[7:5];
    rd  = ins[4:2];
    s5  = {{11{ins[4]}}, ins[4:0]};
    z5  = {11'b0, ins[4:0]};
    s8  = {{8{ins[7]}}, ins[7:0]};
    s11 = {{5{ins[10]}}, ins[10:0]};
    a   = mRegs[rs];
    b   = mRegs[rt];
    // Rs plus simm5, low address bits only
    memIdx = (a + s5) % `CPU16_DMEM_WORDS;
    seqPc  = mPc + 1;

    expEn   = 1'b0;
    expAddr = '0;
    expData = '0;
    nextPc  = seqPc;
    isHalt  = 1'b0;

    case (opc)
        OP_HALT: begin
            isHalt = 1'b1;
            nextPc = mPc;
        end
        OP_J: begin
            nextPc = seqPc + s11;
        end
        OP_JAL: begin
            nextPc  = seqPc + s11;
            expEn   = 1'b1;
            expAddr = `CPU16_LINK_REG;
            expData = seqPc;
        end
        OP_JR: begin
            nextPc = a + s8;
        end
        OP_BEQZ: begin
            if (a == 0) begin
                nextPc = seqPc + s8;
            end
        end
        OP_BNEZ: begin
            if (a != 0) begin
                nextPc = seqPc + s8;
            end
        end
        OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            expEn   = 1'b1;
            expAddr = rt;
            case (opc)
                OP_ADDI: expData = a + s5;
                OP_SUBI: expData = a - s5;
                // Logic immediates are zero extended
                OP_XORI: expData = a ^ z5;
                default: expData = a & ~z5;
            endcase
        end
        OP_ST: begin
            mMem[memIdx] = b;
        end
        OP_LD: begin
            expEn   = 1'b1;
            expAddr = rt;
            expData = mMem[memIdx];
        end
        OP_LBI: begin
            expEn   = 1'b1;
            expAddr = rs;
            expData = s8;
        end
        OP_RFORM: begin
            expEn   = 1'b1;
            expAddr = rd;
            case (ins[1:0])
                2'd0: expData = a + b;
                2'd1: expData = a - b;
                2'd2: expData = a ^ b;
                default: expData = a & ~b;
            endcase
        end
        default: begin
            // NOP and unknown codes
        end
    endcase

    if (expEn) begin
        mRegs[expAddr] = expData;
    end
    mPc = nextPc;
endfunction

`endif

// ==== tb/cpuCoreTb.sv ====
// cpu16 core testbench
`default_nettype none
`include "cpu16_params.svh"

module cpuCoreTb;
    import cpu16Pkg::*;

    localparam int RomWords    = 64;
    localparam int RandLen     = 40;
    localparam int NumRandom   = 20;
    localparam int NumTests    = 5 + NumRandom;
    localparam int ResetCycles = 5;
    localparam int HaltCycles  = 10;
    // Fill loop runs five instructions per word
    localparam int FillSteps   = 6 + 5 * `CPU16_DMEM_WORDS;
    localparam int TotalSteps  = FillSteps + 4 * RomWords + NumRandom * RandLen;
    localparam int TimeoutCycles =
        2 * TotalSteps + NumTests * (ResetCycles + HaltCycles + 3) + 100;

    localparam logic [15:0] HaltWord = 16'h0000;
    localparam logic [15:0] NopWord  = {5'b00001, 11'b0};

    // Target kinds for the random generator
    localparam int KindNone  = 0;
    localparam int KindRel8  = 1;
    localparam int KindRel11 = 2;
    localparam int KindAbs8  = 3;

    logic        clk;
    logic        arstN;
    logic [15:0] instr;
    logic [15:0] instrAddr;
    logic        halted;
    logic        wbEn;
    logic [2:0]  wbAddr;
    logic [15:0] wbData;

    logic [15:0] rom [RomWords];
    logic [15:0] progBuf [RomWords];
    int          progLen;

    logic [31:0] rngState;
    bit          running;
    bit          mHalted;
    int          postHaltCycles;
    int          errCount;
    int          passCount;
    int          failCount;

    // Model outputs for the current instruction
    logic        expEn;
    logic [2:0]  expAddr;
    logic [15:0] expData;
    logic [15:0] expNext;
    logic        expHalt;

    `include "refModel.svh"

    cpuCore UUT (
        .clk(clk),
        .arstN(arstN),
        .instr(instr),
        .instrAddr(instrAddr),
        .halted(halted),
        .wbEn(wbEn),
        .wbAddr(wbAddr),
        .wbData(wbData)
    );

    always #5 clk = ~clk;

    // Program ROM answers in the same cycle
    assign instr = rom[instrAddr[5:0]];

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic int randBelow(input int n);
        return int'(nextRandom() % n);
    endfunction

    // Instruction encoders
    function automatic logic [15:0] encodeR(input int fn, input int rd, input int rs,
                                            input int rt);
        return {OP_RFORM, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
    endfunction

    function automatic logic [15:0] encodeI(input logic [4:0] op, input int rs, input int rt,
                                            input int imm);
        return {op, 3'(rs), 3'(rt), 5'(imm)};
    endfunction

    function automatic logic [15:0] encodeB(input logic [4:0] op, input int rs, input int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    function automatic logic [15:0] encodeJ(input logic [4:0] op, input int imm);
        return {op, 11'(imm)};
    endfunction

    task automatic clearProgram();
        progLen = 0;
    endtask

    task automatic appendInstr(input logic [15:0] word);
        progBuf[progLen] = word;
        progLen++;
    endtask

    task automatic reportMismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        $display("** Error at time %0t: %s expected 0x%04h, got 0x%04h",
                 $time, name, expected, actual);
        errCount++;
    endtask

    // Loads the ROM under reset, then releases it
    task automatic applyReset();
        int i;
        @(posedge clk);
        arstN <= 1'b0;
        for (i = 0; i < RomWords; i++) begin
            rom[i] <= (i < progLen) ? progBuf[i] : HaltWord;
        end
        repeat (ResetCycles - 1) @(posedge clk);
        @(negedge clk);
        if (instrAddr !== 16'h0000) begin
            reportMismatch("instrAddr", 16'h0000, instrAddr);
        end
        if (halted !== 1'b0) begin
            reportMismatch("halted", 16'h0000, {15'b0, halted});
        end
        @(posedge clk);
        arstN <= 1'b1;
        resetModel();
        mHalted        = 1'b0;
        postHaltCycles = 0;
    endtask

    task automatic runTest(input string name);
        int errsBefore;
        errsBefore = errCount;
        applyReset();
        running = 1'b1;
        wait (!running);
        if (errCount == errsBefore) begin
            passCount++;
            $display("Test %s: passed", name);
        end else begin
            failCount++;
            $display("Test %s: failed with %0d errors", name, errCount - errsBefore);
        end
    endtask

    // Step check at mid-cycle, model advances with each instruction
    always @(negedge clk) begin
        if (running) begin
            if (!mHalted) begin
                if (instrAddr !== mPc) begin
                    reportMismatch("instrAddr", mPc, instrAddr);
                end
                if (halted !== 1'b0) begin
                    reportMismatch("halted", 16'h0000, {15'b0, halted});
                end
                refStep(progBuf[mPc % RomWords], expEn, expAddr, expData, expNext, expHalt);
                if (wbEn !== expEn) begin
                    reportMismatch("wbEn", {15'b0, expEn}, {15'b0, wbEn});
                end
                if (expEn) begin
                    if (wbAddr !== expAddr) begin
                        reportMismatch("wbAddr", {13'b0, expAddr}, {13'b0, wbAddr});
                    end
                    if (wbData !== expData) begin
                        reportMismatch("wbData", expData, wbData);
                    end
                end
                mHalted = expHalt;
            end else begin
                // Frozen PC, no write-backs
                if (instrAddr !== mPc) begin
                    reportMismatch("instrAddr", mPc, instrAddr);
                end
                if (halted !== 1'b1) begin
                    reportMismatch("halted", 16'h0001, {15'b0, halted});
                end
                if (wbEn !== 1'b0) begin
                    reportMismatch("wbEn", 16'h0000, {15'b0, wbEn});
                end
                postHaltCycles++;
                if (postHaltCycles == HaltCycles) begin
                    running = 1'b0;
                end
            end
        end
    end

    // Forward-only targets, so every program reaches HALT
    task automatic buildRandomProgram();
        int i;
        int t;
        int r;
        int kind [RandLen];
        int target [RandLen];
        bit jrSlot [RandLen];
        logic [4:0] op;
        for (i = 0; i < RandLen; i++) begin
            kind[i]   = KindNone;
            target[i] = 0;
            jrSlot[i] = 1'b0;
        end
        i = 0;
        while (i < RandLen - 1) begin
            case (randBelow(10))
                0, 1: begin
                    progBuf[i] = encodeR(randBelow(4), randBelow(8), randBelow(8), randBelow(8));
                end
                2, 3: begin
                    case (randBelow(4))
                        0: op = OP_ADDI;
                        1: op = OP_SUBI;
                        2: op = OP_XORI;
                        default: op = OP_ANDNI;
                    endcase
                    progBuf[i] = encodeI(op, randBelow(8), randBelow(8), randBelow(32));
                end
                4: begin
                    op = randBelow(2) ? OP_LD : OP_ST;
                    progBuf[i] = encodeI(op, randBelow(8), randBelow(8), randBelow(32));
                end
                5: begin
                    progBuf[i] = encodeB(OP_LBI, randBelow(8), randBelow(256));
                end
                6: begin
                    op         = randBelow(2) ? OP_BEQZ : OP_BNEZ;
                    progBuf[i] = encodeB(op, randBelow(8), 0);
                    kind[i]    = KindRel8;
                    target[i]  = i + 1 + randBelow(RandLen - 1 - i);
                end
                7: begin
                    op         = randBelow(2) ? OP_J : OP_JAL;
                    progBuf[i] = encodeJ(op, 0);
                    kind[i]    = KindRel11;
                    target[i]  = i + 1 + randBelow(RandLen - 1 - i);
                end
                8: begin
                    // LBI of the absolute target, then JR through it
                    if (i < RandLen - 2) begin
                        r              = randBelow(8);
                        progBuf[i]     = encodeB(OP_LBI, r, 0);
                        kind[i]        = KindAbs8;
                        target[i]      = i + 2 + randBelow(RandLen - 2 - i);
                        progBuf[i + 1] = encodeB(OP_JR, r, 0);
                        jrSlot[i + 1]  = 1'b1;
                        i++;
                    end else begin
                        progBuf[i] = NopWord;
                    end
                end
                default: begin
                    // Unknown opcode 11111 must act as NOP
                    progBuf[i] = randBelow(2) ? NopWord : {5'b11111, 11'(randBelow(2048))};
                end
            endcase
            i++;
        end
        // Never land between an LBI and its JR
        for (i = 0; i < RandLen - 1; i++) begin
            t = target[i];
            if (kind[i] != KindNone && jrSlot[t]) begin
                t++;
            end
            case (kind[i])
                KindRel8:  progBuf[i][7:0]  = 8'(t - i - 1);
                KindRel11: progBuf[i][10:0] = 11'(t - i - 1);
                KindAbs8:  progBuf[i][7:0]  = 8'(t);
                default: ;
            endcase
        end
        progBuf[RandLen - 1] = HaltWord;
        progLen = RandLen;
    endtask

    // Ends a run that never halts
    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout: a program never reached HALT within %0d cycles", TimeoutCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int n;
        int i;
        clk       = 1'b0;
        arstN     = 1'b0;
        running   = 1'b0;
        mHalted   = 1'b0;
        errCount  = 0;
        passCount = 0;
        failCount = 0;
        rngState  = 32'd48850;
        for (i = 0; i < RomWords; i++) begin
            rom[i]     = HaltWord;
            progBuf[i] = HaltWord;
        end

        // Quiet start, then sign-extended LBI
        clearProgram();
        appendInstr(NopWord);
        appendInstr(NopWord);
        appendInstr(encodeB(OP_LBI, 3, 8'h80));
        appendInstr(encodeB(OP_LBI, 4, 8'h7F));
        appendInstr(HaltWord);
        runTest("reset");

        // Register and immediate ALU forms
        clearProgram();
        appendInstr(encodeB(OP_LBI, 1, 8'h35));
        appendInstr(encodeB(OP_LBI, 2, -100));
        appendInstr(encodeR(ALU_ADD, 3, 1, 2));
        appendInstr(encodeR(ALU_SUB, 4, 1, 2));
        appendInstr(encodeR(ALU_XOR, 5, 1, 2));
        appendInstr(encodeR(ALU_ANDN, 6, 1, 2));
        appendInstr(encodeI(OP_ADDI, 1, 3, -16));
        appendInstr(encodeI(OP_SUBI, 2, 4, -1));
        appendInstr(encodeI(OP_XORI, 2, 5, 31));
        appendInstr(encodeI(OP_ANDNI, 2, 6, 5'h1C));
        appendInstr(encodeI(OP_XORI, 1, 0, 5'h10));
        appendInstr(encodeR(ALU_SUB, 7, 2, 2));
        appendInstr({5'b11111, 11'h5A5});
        appendInstr(encodeR(ALU_ADD, 0, 7, 1));
        appendInstr(HaltWord);
        runTest("alu");

        // Fills every data word with addr xor 0xFFA5
        clearProgram();
        appendInstr(encodeB(OP_LBI, 1, 0));
        appendInstr(encodeB(OP_LBI, 3, 8'hA5));
        appendInstr(encodeB(OP_LBI, 6, 64));
        appendInstr(encodeR(ALU_ADD, 6, 6, 6));
        appendInstr(encodeR(ALU_ADD, 6, 6, 6));
        appendInstr(encodeR(ALU_XOR, 2, 1, 3));
        appendInstr(encodeI(OP_ST, 1, 2, 0));
        appendInstr(encodeI(OP_ADDI, 1, 1, 1));
        appendInstr(encodeR(ALU_XOR, 5, 1, 6));
        appendInstr(encodeB(OP_BNEZ, 5, -5));
        appendInstr(HaltWord);
        runTest("memory fill");

        // ST then LD, overwrite and address wrap
        clearProgram();
        appendInstr(encodeB(OP_LBI, 1, 8'h12));
        appendInstr(encodeB(OP_LBI, 2, -7));
        appendInstr(encodeI(OP_ST, 1, 2, 3));
        appendInstr(encodeB(OP_LBI, 3, 8'h40));
        appendInstr(encodeI(OP_ST, 1, 3, -2));
        appendInstr(encodeI(OP_LD, 1, 4, 3));
        appendInstr(encodeI(OP_LD, 1, 5, -2));
        appendInstr(encodeI(OP_ST, 1, 1, 3));
        appendInstr(encodeI(OP_LD, 1, 6, 3));
        appendInstr(encodeB(OP_LBI, 1, -1));
        appendInstr(encodeI(OP_ST, 1, 2, 0));
        appendInstr(encodeI(OP_LD, 1, 7, 0));
        appendInstr(encodeI(OP_LD, 1, 0, 1));
        appendInstr(HaltWord);
        runTest("memory");

        // Branches both ways, J forward and back, JAL and JR
        clearProgram();
        appendInstr(encodeB(OP_LBI, 1, 0));
        appendInstr(encodeB(OP_BEQZ, 1, 1));
        appendInstr(encodeB(OP_LBI, 2, 8'h11));
        appendInstr(encodeB(OP_BNEZ, 1, 5));
        appendInstr(encodeB(OP_LBI, 2, 5));
        appendInstr(encodeB(OP_BNEZ, 2, 1));
        appendInstr(encodeB(OP_LBI, 3, 8'h22));
        appendInstr(encodeB(OP_BEQZ, 2, 7));
        appendInstr(encodeJ(OP_J, 3));
        appendInstr(encodeI(OP_ADDI, 4, 4, 1));
        appendInstr(encodeJ(OP_JAL, 3));
        appendInstr(encodeJ(OP_J, 4));
        appendInstr(NopWord);
        appendInstr(encodeJ(OP_J, -5));
        appendInstr(encodeI(OP_ADDI, 5, 5, 3));
        appendInstr(encodeB(OP_JR, 7, 0));
        appendInstr(HaltWord);
        runTest("control flow");

        for (n = 0; n < NumRandom; n++) begin
            buildRandomProgram();
            runTest($sformatf("random %0d", n));
        end

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cpuCore.sv ====
// Single-cycle cpu16 core
`default_nettype none
`include "cpu16_params.svh"

module cpuCore (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [`CPU16_WIDTH-1:0]         instr,
    output logic [`CPU16_WIDTH-1:0]         instrAddr,
    output logic                            halted,
    output logic                            wbEn,
    output logic [$clog2(`CPU16_REGS)-1:0]  wbAddr,
    output logic [`CPU16_WIDTH-1:0]         wbData
);
    import cpu16Pkg::*;

    localparam int W   = `CPU16_WIDTH;
    localparam int RAW = $clog2(`CPU16_REGS);
    localparam logic [RAW-1:0] LINK_ADDR = RAW'(`CPU16_LINK_REG);

    // Decoder levels
    aluOpT      aluOp;
    immSelT     immSel;
    pcSelT      pcSel;
    logic       aluSrcImm;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic [1:0] wbSel;
    logic [1:0] dstSel;
    logic       isBranch;
    logic       branchNotZero;
    logic       halt;

    // Datapath
    logic [W-1:0] rsData;
    logic [W-1:0] rtData;
    logic [W-1:0] imm;
    logic [W-1:0] aluInB;
    logic [W-1:0] aluResult;
    logic [W-1:0] memData;
    logic [W-1:0] pc;
    logic [W-1:0] pcPlusOne;

    instrDecoder decoder (
        .instr(instr),
        .aluOp(aluOp),
        .immSel(immSel),
        .pcSel(pcSel),
        .aluSrcImm(aluSrcImm),
        .regWrite(regWrite),
        .memRead(memRead),
        .memWrite(memWrite),
        .wbSel(wbSel),
        .dstSel(dstSel),
        .isBranch(isBranch),
        .branchNotZero(branchNotZero),
        .halt(halt)
    );

    fetchUnit fetch (
        .clk(clk),
        .arstN(arstN),
        .pcSel(pcSel),
        .isBranch(isBranch),
        .branchNotZero(branchNotZero),
        .halt(halt),
        .imm(imm),
        .rsData(rsData),
        .pc(pc),
        .pcPlusOne(pcPlusOne),
        .halted(halted)
    );

    // Instruction ROM lives outside, answers in the same cycle
    assign instrAddr = pc;

    // Immediate extender
    always_comb begin
        case (immSel)
            IMM5S:   imm = {{(W-5){instr[4]}}, instr[4:0]};
            IMM5Z:   imm = {{(W-5){1'b0}}, instr[4:0]};
            IMM8S:   imm = {{(W-8){instr[7]}}, instr[7:0]};
            IMM11S:  imm = {{(W-11){instr[10]}}, instr[10:0]};
            default: imm = '0;
        endcase
    end

    // Destination field
    always_comb begin
        case (dstSel)
            DST_RD:  wbAddr = instr[4:2];
            DST_RT:  wbAddr = instr[7:5];
            DST_RS:  wbAddr = instr[10:8];
            default: wbAddr = LINK_ADDR;
        endcase
    end

    // No writes once stopped
    assign wbEn = regWrite && !halted;

    regFile regs (
        .clk(clk),
        .arstN(arstN),
        .rdAddrA(instr[10:8]),
        .rdAddrB(instr[7:5]),
        .wrEn(wbEn),
        .wrAddr(wbAddr),
        .wrData(wbData),
        .rdDataA(rsData),
        .rdDataB(rtData)
    );

    // Operand B, Rt or immediate
    assign aluInB = aluSrcImm ? imm : rtData;

    // Zero flag not needed, branch test sits in fetch
    alu aluUnit (
        .op(aluOp),
        .inA(rsData),
        .inB(aluInB),
        .result(aluResult),
        .zero()
    );

    dataMem dmem (
        .clk(clk),
        .addr(aluResult),
        .wrEn(memWrite && !halted),
        .wrData(rtData),
        .rdData(memData)
    );

    // Write-back source
    always_comb begin
        case (wbSel)
            WB_ALU:  wbData = aluResult;
            WB_MEM:  wbData = memRead ? memData : '0;
            WB_LINK: wbData = pcPlusOne;
            default: wbData = imm;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/dataMem.sv ====
// Data RAM
`default_nettype none
`include "cpu16_params.svh"

module dataMem (
    input  logic                    clk,
    input  logic [`CPU16_WIDTH-1:0] addr,
    input  logic                    wrEn,
    input  logic [`CPU16_WIDTH-1:0] wrData,
    output logic [`CPU16_WIDTH-1:0] rdData
);

    localparam int AW = $clog2(`CPU16_DMEM_WORDS);

    logic [`CPU16_WIDTH-1:0] mem [`CPU16_DMEM_WORDS];
    logic [AW-1:0]           index;

    // Upper address bits ignored, RAM aliases
    assign index = addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[index] <= wrData;
        end
    end

    // Asynchronous read
    assign rdData = mem[index];

    wrIndexKnown: assert property (
        @(posedge clk) wrEn |-> !$isunknown(index)
    ) else $error("dataMem: store to unknown address");

endmodule

`default_nettype wire

// ==== verilog/fetchUnit.sv ====
// Program counter and next-PC logic
`default_nettype none
`include "cpu16_params.svh"

module fetchUnit (
    input  logic                    clk,
    input  logic                    arstN,
    input  cpu16Pkg::pcSelT         pcSel,
    input  logic                    isBranch,
    input  logic                    branchNotZero,
    input  logic                    halt,
    input  logic [`CPU16_WIDTH-1:0] imm,
    input  logic [`CPU16_WIDTH-1:0] rsData,
    output logic [`CPU16_WIDTH-1:0] pc,
    output logic [`CPU16_WIDTH-1:0] pcPlusOne,
    output logic                    halted
);
    import cpu16Pkg::*;

    logic [`CPU16_WIDTH-1:0] relTarget;
    logic [`CPU16_WIDTH-1:0] nextPc;
    logic                    rsNonZero;
    logic                    relTaken;

    // Word addresses, so step by one
    assign pcPlusOne = pc + 1'b1;
    // Relative targets count from the next instruction
    assign relTarget = pcPlusOne + imm;

    // Zero test on Rs
    assign rsNonZero = |rsData;
    // Jumps always taken, branches on the test
    assign relTaken  = !isBranch || (rsNonZero == branchNotZero);

    always_comb begin
        case (pcSel)
            PC_SEQ: begin
                nextPc = pcPlusOne;
            end
            PC_REL8, PC_REL11: begin
                nextPc = relTaken ? relTarget : pcPlusOne;
            end
            PC_REG: begin
                nextPc = rsData + imm;
            end
            default: begin
                nextPc = pcPlusOne;
            end
        endcase
    end

    // HALT freezes the PC, flag sticks until reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (halt || halted) begin
            halted <= 1'b1;
        end else begin
            pc <= nextPc;
        end
    end

    pcFrozen: assert property (
        @(posedge clk) disable iff (!arstN)
        halted |=> $stable(pc)
    ) else $error("fetchUnit: PC moved while halted");

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
// Four-function ALU
`default_nettype none
`include "cpu16_params.svh"

module alu (
    input  cpu16Pkg::aluOpT         op,
    input  logic [`CPU16_WIDTH-1:0] inA,
    input  logic [`CPU16_WIDTH-1:0] inB,
    output logic [`CPU16_WIDTH-1:0] result,
    output logic                    zero
);
    import cpu16Pkg::*;

    logic [`CPU16_WIDTH-1:0] sum;
    logic [`CPU16_WIDTH-1:0] diff;

    // Carry out dropped, wraps mod 2^16
    assign sum  = inA + inB;
    // Rs minus operand B
    assign diff = inA - inB;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_XOR: begin
                result = inA ^ inB;
            end
            ALU_ANDN: begin
                // Clear the bits set in B
                result = inA & ~inB;
            end
            default: begin
                result = sum;
            end
        endcase
    end

    // All-zero result
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
// Eight-entry register file
`default_nettype none
`include "cpu16_params.svh"

module regFile (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [$clog2(`CPU16_REGS)-1:0]  rdAddrA,
    input  logic [$clog2(`CPU16_REGS)-1:0]  rdAddrB,
    input  logic                            wrEn,
    input  logic [$clog2(`CPU16_REGS)-1:0]  wrAddr,
    input  logic [`CPU16_WIDTH-1:0]         wrData,
    output logic [`CPU16_WIDTH-1:0]         rdDataA,
    output logic [`CPU16_WIDTH-1:0]         rdDataB
);

    logic [`CPU16_WIDTH-1:0] regs [`CPU16_REGS];

    // All registers come up zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Rs port
    assign rdDataA = regs[rdAddrA];
    // Rt port
    assign rdDataB = regs[rdAddrB];

    // Write target must resolve before the commit edge
    wrAddrKnown: assert property (
        @(posedge clk) disable iff (!arstN)
        wrEn |-> !$isunknown(wrAddr)
    ) else $error("regFile: write with unknown address");

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
// Instruction decoder
`default_nettype none
`include "cpu16_params.svh"

module instrDecoder (
    input  logic [`CPU16_WIDTH-1:0] instr,
    output cpu16Pkg::aluOpT         aluOp,
    output cpu16Pkg::immSelT        immSel,
    output cpu16Pkg::pcSelT         pcSel,
    output logic                    aluSrcImm,
    output logic                    regWrite,
    output logic                    memRead,
    output logic                    memWrite,
    output logic [1:0]              wbSel,
    output logic [1:0]              dstSel,
    output logic                    isBranch,
    output logic                    branchNotZero,
    output logic                    halt
);
    import cpu16Pkg::*;

    opcodeT opcode;

    assign opcode = opcodeT'(instr[15:11]);

    always_comb begin
        // Quiet defaults, also what unknown codes get
        aluOp         = ALU_ADD;
        immSel        = IMM5S;
        pcSel         = PC_SEQ;
        aluSrcImm     = 1'b0;
        regWrite      = 1'b0;
        memRead       = 1'b0;
        memWrite      = 1'b0;
        wbSel         = WB_ALU;
        dstSel        = DST_RD;
        isBranch      = 1'b0;
        branchNotZero = 1'b0;
        halt          = 1'b0;

        case (opcode)
            OP_HALT: begin
                halt = 1'b1;
            end
            OP_NOP: begin
                // Nothing beyond pc+1
            end
            OP_J: begin
                immSel = IMM11S;
                pcSel  = PC_REL11;
            end
            OP_JAL: begin
                immSel   = IMM11S;
                pcSel    = PC_REL11;
                regWrite = 1'b1;
                wbSel    = WB_LINK;
                dstSel   = DST_LINK;
            end
            OP_JR: begin
                // Target is Rs plus imm8
                immSel = IMM8S;
                pcSel  = PC_REG;
            end
            OP_BEQZ, OP_BNEZ: begin
                immSel        = IMM8S;
                pcSel         = PC_REL8;
                isBranch      = 1'b1;
                branchNotZero = (opcode == OP_BNEZ);
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                // Low two opcode bits pick the ALU op
                aluOp     = aluOpT'(instr[12:11]);
                immSel    = instr[12] ? IMM5Z : IMM5S;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                dstSel    = DST_RT;
            end
            OP_ST: begin
                // Address is Rs plus imm5, data from Rt
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            OP_LD: begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
                wbSel     = WB_MEM;
                dstSel    = DST_RT;
            end
            OP_LBI: begin
                immSel   = IMM8S;
                regWrite = 1'b1;
                wbSel    = WB_IMM;
                dstSel   = DST_RS;
            end
            OP_RFORM: begin
                aluOp    = aluOpT'(instr[1:0]);
                regWrite = 1'b1;
            end
            default: begin
                // Undefined opcode behaves as NOP
            end
        endcase
    end

    // One RAM access kind per instruction
    memExclusive: assert #0 (!(memRead && memWrite))
        else $error("instrDecoder: memRead and memWrite both high");

endmodule

`default_nettype wire

// ==== verilog/cpu16Pkg.sv ====
// Shared core types
`default_nettype none

package cpu16Pkg;

    // Primary opcode in instr[15:11]
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_LBI   = 5'b11000,
        OP_RFORM = 5'b11011
    } opcodeT;

    // Same order as the R-format func field
    typedef enum logic [1:0] {
        ALU_ADD  = 2'd0,
        ALU_SUB  = 2'd1,
        ALU_XOR  = 2'd2,
        ALU_ANDN = 2'd3
    } aluOpT;

    // Immediate field width and extension
    typedef enum logic [1:0] {
        IMM5S  = 2'd0,
        IMM5Z  = 2'd1,
        IMM8S  = 2'd2,
        IMM11S = 2'd3
    } immSelT;

    // Next PC source
    typedef enum logic [1:0] {
        PC_SEQ   = 2'd0,
        PC_REL8  = 2'd1,
        PC_REL11 = 2'd2,
        PC_REG   = 2'd3
    } pcSelT;

    // Write-back data sources
    localparam logic [1:0] WB_ALU  = 2'd0;
    localparam logic [1:0] WB_MEM  = 2'd1;
    localparam logic [1:0] WB_LINK = 2'd2;
    localparam logic [1:0] WB_IMM  = 2'd3;

    // Destination register field
    localparam logic [1:0] DST_RD   = 2'd0;
    localparam logic [1:0] DST_RT   = 2'd1;
    localparam logic [1:0] DST_RS   = 2'd2;
    localparam logic [1:0] DST_LINK = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/cpu16_params.svh ====
// Core sizing constants
`ifndef CPU16_PARAMS_SVH
`define CPU16_PARAMS_SVH

// Datapath and instruction width
`define CPU16_WIDTH 16

// Architectural registers R0 to R7
`define CPU16_REGS 8

// Data RAM depth in words
`define CPU16_DMEM_WORDS 256

// Register written by JAL
`define CPU16_LINK_REG 7

`endif
